//--- logic/nn_ex_defines.svh
// Widths and counts for the execute stage; include wherever a port or array is sized

`ifndef NN_EX_DEFINES_SVH
`define NN_EX_DEFINES_SVH

//////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////

`define NN_XLEN    32  // Data word width
`define NN_REG_AW  6   // GPR address incl. FP bank bit

//////////////////////////////////////////////////
// Special registers
//////////////////////////////////////////////////

// Weight group
`define NN_N_WSPR  4
`define NN_WSPR_IW 2

// Activation group
`define NN_N_ASPR  2
`define NN_ASPR_IW 1

`endif

//--- logic/nn_ex_pkg.sv
// Operator encodings and the SIMD word view shared by the execute stage units

`include "nn_ex_defines.svh"

package nn_ex_pkg;

  // Integer ALU operator
  typedef enum logic [1:0] {
    ALU_ADD = 2'b00,
    ALU_SUB = 2'b01,
    ALU_SLT = 2'b10, // Signed less-than
    ALU_EQ  = 2'b11
  } nn_alu_op_e;

  // Lane width of the dot product
  typedef enum logic {
    DOT8  = 1'b0,
    DOT16 = 1'b1
  } nn_dot_mode_e;

  // One operand word, read as bytes or as halfwords
  typedef union packed {
    logic [`NN_XLEN/8-1:0][7:0]   lane8;
    logic [`NN_XLEN/16-1:0][15:0] lane16;
  } nn_simd_word_u;

endpackage

//--- logic/nn_alu.sv
// Integer ALU of the execute stage; result goes to forwarding, compare drives the branch

`timescale 1ns/10ps

`include "nn_ex_defines.svh"

module nn_alu (
  input  nn_ex_pkg::nn_alu_op_e operator_i,
  input  logic [`NN_XLEN-1:0]   operand_a_i,
  input  logic [`NN_XLEN-1:0]   operand_b_i,
  output logic [`NN_XLEN-1:0]   result_o,
  output logic                  cmp_result_o
);

  logic [`NN_XLEN-1:0] sum;
  logic [`NN_XLEN-1:0] diff;
  logic                lt_signed;
  logic                is_equal;

  assign sum       = operand_a_i + operand_b_i;
  assign diff      = operand_a_i - operand_b_i;
  assign lt_signed = $signed(operand_a_i) < $signed(operand_b_i);
  assign is_equal  = (operand_a_i == operand_b_i);

  always_comb begin
    result_o     = sum;
    cmp_result_o = 1'b0; // No branch outcome for arithmetic ops
    case (operator_i)
      nn_ex_pkg::ALU_ADD: result_o = sum;
      nn_ex_pkg::ALU_SUB: result_o = diff;
      nn_ex_pkg::ALU_SLT: begin
        result_o     = {{(`NN_XLEN-1){1'b0}}, lt_signed};
        cmp_result_o = lt_signed;
      end
      nn_ex_pkg::ALU_EQ: begin
        result_o     = {{(`NN_XLEN-1){1'b0}}, is_equal};
        cmp_result_o = is_equal;
      end
      default: result_o = sum;
    endcase
  end

endmodule

//--- logic/nn_dotp_unit.sv
// SIMD dot product with accumulator; operands come from the ports or the special registers

`timescale 1ns/10ps

`include "nn_ex_defines.svh"

module nn_dotp_unit (
  input  nn_ex_pkg::nn_dot_mode_e dot_mode_i,
  input  logic                    dot_signed_i,
  input  logic                    dot_spr_i,    // Load-and-compute form
  input  logic [`NN_XLEN-1:0]     op_a_i,
  input  logic [`NN_XLEN-1:0]     op_b_i,
  input  logic [`NN_XLEN-1:0]     op_c_i,       // Accumulator
  input  logic [`NN_XLEN-1:0]     spr_w_i,
  input  logic [`NN_XLEN-1:0]     spr_a_i,
  output logic [`NN_XLEN-1:0]     result_o
);

  nn_ex_pkg::nn_simd_word_u opa;
  nn_ex_pkg::nn_simd_word_u opb;

  logic signed [`NN_XLEN-1:0] sum8;
  logic signed [`NN_XLEN-1:0] sum16;

  // Weights on a, activations on b
  assign opa = dot_spr_i ? spr_w_i : op_a_i;
  assign opb = dot_spr_i ? spr_a_i : op_b_i;

  //////////////////////////////////////////////////
  // Lane products
  //////////////////////////////////////////////////

  // One extra bit per lane holds the sign, or zero when unsigned
  always_comb begin
    logic signed [8:0]  ea8;
    logic signed [8:0]  eb8;
    logic signed [16:0] ea16;
    logic signed [16:0] eb16;
    sum8  = '0;
    sum16 = '0;
    for (int i = 0; i < `NN_XLEN/8; i++) begin
      ea8  = {dot_signed_i & opa.lane8[i][7], opa.lane8[i]};
      eb8  = {dot_signed_i & opb.lane8[i][7], opb.lane8[i]};
      sum8 = sum8 + ea8 * eb8;
    end
    for (int j = 0; j < `NN_XLEN/16; j++) begin
      ea16  = {dot_signed_i & opa.lane16[j][15], opa.lane16[j]};
      eb16  = {dot_signed_i & opb.lane16[j][15], opb.lane16[j]};
      sum16 = sum16 + ea16 * eb16;
    end
  end

  // Wraps at 32 bits
  assign result_o = op_c_i + ((dot_mode_i == nn_ex_pkg::DOT16) ? sum16 : sum8);

endmodule

//--- logic/nn_spr_file.sv
// Weight and activation registers, filled by loads in WB and read by the load-and-compute dot

`timescale 1ns/10ps

`include "nn_ex_defines.svh"

module nn_spr_file (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ex_valid_i,
  input  logic                   wb_ready_i,
  input  logic                   lsu_spr_i,
  input  logic [2:0]             lsu_spr_sel_i,  // {group, index}
  input  logic                   data_rvalid_i,
  input  logic [`NN_XLEN-1:0]    lsu_rdata_i,
  input  logic [`NN_WSPR_IW-1:0] w_idx_i,
  input  logic [`NN_ASPR_IW-1:0] a_idx_i,
  output logic [`NN_XLEN-1:0]    spr_w_o,
  output logic [`NN_XLEN-1:0]    spr_a_o
);

  logic [`NN_N_WSPR-1:0][`NN_XLEN-1:0] wspr_q;
  logic [`NN_N_ASPR-1:0][`NN_XLEN-1:0] aspr_q;

  logic       pend_q;   // SPR load sitting in WB
  logic [2:0] sel_q;
  logic       spr_we;

  // Load target follows the instruction into WB
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else if (ex_valid_i) begin
      pend_q <= lsu_spr_i;
    end else if (wb_ready_i) begin
      pend_q <= 1'b0; // Bubble
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_i) sel_q <= lsu_spr_sel_i;
  end

  assign spr_we = pend_q & data_rvalid_i;

  //////////////////////////////////////////////////
  // Register array
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wspr_q <= '0;
      aspr_q <= '0;
    end else if (spr_we) begin
      if (sel_q[`NN_WSPR_IW]) wspr_q[sel_q[`NN_WSPR_IW-1:0]] <= lsu_rdata_i;
      else                    aspr_q[sel_q[`NN_ASPR_IW-1:0]] <= lsu_rdata_i;
    end
  end

  // Old contents seen by a dot in the same cycle as the write
  assign spr_w_o = wspr_q[w_idx_i];
  assign spr_a_o = aspr_q[a_idx_i];

endmodule

//--- logic/nn_writeback.sv
// Forwarding mux, EX/WB pipeline register, writeback mux and the ex_ready/ex_valid stall logic

`timescale 1ns/10ps

`include "nn_ex_defines.svh"

module nn_writeback (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  alu_en_i,
  input  logic                  dot_en_i,
  input  logic                  lsu_en_i,
  input  logic                  dot_spr_i,
  input  logic                  branch_in_ex_i,
  input  logic [`NN_XLEN-1:0]   alu_result_i,
  input  logic [`NN_XLEN-1:0]   dot_result_i,

  input  logic                  regfile_alu_we_i,
  input  logic [`NN_REG_AW-1:0] regfile_alu_waddr_i,
  input  logic [`NN_REG_AW-1:0] regfile_alu_waddr2_i,
  input  logic                  regfile_we_i,
  input  logic [`NN_REG_AW-1:0] regfile_waddr_i,
  input  logic                  lsu_err_i,
  input  logic                  lsu_ready_ex_i,
  input  logic [`NN_XLEN-1:0]   lsu_rdata_i,
  input  logic                  wb_ready_i,

  output logic                  regfile_alu_we_fw_o,
  output logic [`NN_REG_AW-1:0] regfile_alu_waddr_fw_o,
  output logic [`NN_XLEN-1:0]   regfile_alu_wdata_fw_o,
  output logic                  regfile_we_wb_o,
  output logic [`NN_REG_AW-1:0] regfile_waddr_wb_o,
  output logic [`NN_XLEN-1:0]   regfile_wdata_wb_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic                  load_we_q;
  logic                  dot_wb_q;   // Deferred dot of a load-and-compute
  logic [`NN_REG_AW-1:0] load_waddr_q;
  logic [`NN_REG_AW-1:0] waddr2_q;
  logic [`NN_XLEN-1:0]   dot_result_q;

  //////////////////////////////////////////////////
  // Stall control
  //////////////////////////////////////////////////

  // Branches resolve here and never need WB
  assign ex_ready_o = (lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | dot_en_i | lsu_en_i) & lsu_ready_ex_i & wb_ready_i;

  // Forwarding port, ALU wins for load-and-compute
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign regfile_alu_wdata_fw_o = (dot_en_i & ~dot_spr_i) ? dot_result_i : alu_result_i;

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      load_we_q <= 1'b0;
      dot_wb_q  <= 1'b0;
    end else if (ex_valid_o) begin // wb_ready_i implied
      load_we_q <= regfile_we_i & ~lsu_err_i;
      dot_wb_q  <= dot_spr_i & dot_en_i;
    end else if (wb_ready_i) begin
      load_we_q <= 1'b0;
      dot_wb_q  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o) begin
      load_waddr_q <= regfile_waddr_i;
      waddr2_q     <= regfile_alu_waddr2_i;
      dot_result_q <= dot_result_i;
    end
  end

  // Load data arrives in WB, dot result was captured in EX
  always_comb begin
    regfile_we_wb_o    = load_we_q | dot_wb_q;
    regfile_waddr_wb_o = load_waddr_q;
    regfile_wdata_wb_o = lsu_rdata_i;
    if (dot_wb_q) begin
      regfile_waddr_wb_o = waddr2_q;
      regfile_wdata_wb_o = dot_result_q;
    end
  end

endmodule

//--- logic/nn_ex_stage.sv
// Top of the execute stage; wires ALU, dot unit, special registers and writeback together

`timescale 1ns/10ps

`include "nn_ex_defines.svh"

module nn_ex_stage (
  input  logic                    clk,
  input  logic                    rst_n,

  // ALU
  input  logic                    alu_en_i,
  input  nn_ex_pkg::nn_alu_op_e   alu_op_i,
  input  logic [`NN_XLEN-1:0]     alu_operand_a_i,
  input  logic [`NN_XLEN-1:0]     alu_operand_b_i,
  input  logic                    branch_in_ex_i,

  // Dot product
  input  logic                    dot_en_i,
  input  nn_ex_pkg::nn_dot_mode_e dot_mode_i,
  input  logic                    dot_signed_i,
  input  logic [`NN_XLEN-1:0]     dot_op_a_i,
  input  logic [`NN_XLEN-1:0]     dot_op_b_i,
  input  logic [`NN_XLEN-1:0]     dot_op_c_i,
  input  logic                    dot_spr_i,
  input  logic [`NN_WSPR_IW-1:0]  spr_w_idx_i,
  input  logic [`NN_ASPR_IW-1:0]  spr_a_idx_i,

  input  logic                    regfile_alu_we_i,
  input  logic [`NN_REG_AW-1:0]   regfile_alu_waddr_i,
  input  logic [`NN_REG_AW-1:0]   regfile_alu_waddr2_i,

  // LSU
  input  logic                    lsu_en_i,
  input  logic                    regfile_we_i,
  input  logic [`NN_REG_AW-1:0]   regfile_waddr_i,
  input  logic                    lsu_spr_i,
  input  logic [2:0]              lsu_spr_sel_i,
  input  logic                    lsu_err_i,
  input  logic                    lsu_ready_ex_i,
  input  logic [`NN_XLEN-1:0]     lsu_rdata_i,
  input  logic                    data_rvalid_i,

  input  logic                    wb_ready_i,

  output logic                    branch_decision_o,
  output logic                    regfile_alu_we_fw_o,
  output logic [`NN_REG_AW-1:0]   regfile_alu_waddr_fw_o,
  output logic [`NN_XLEN-1:0]     regfile_alu_wdata_fw_o,
  output logic                    regfile_we_wb_o,
  output logic [`NN_REG_AW-1:0]   regfile_waddr_wb_o,
  output logic [`NN_XLEN-1:0]     regfile_wdata_wb_o,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);

  logic [`NN_XLEN-1:0] alu_result;
  logic [`NN_XLEN-1:0] dot_result;
  logic [`NN_XLEN-1:0] spr_w;
  logic [`NN_XLEN-1:0] spr_a;

  nn_alu u_alu (
    .operator_i   (alu_op_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  nn_dotp_unit u_dotp (
    .dot_mode_i   (dot_mode_i),
    .dot_signed_i (dot_signed_i),
    .dot_spr_i    (dot_spr_i),
    .op_a_i       (dot_op_a_i),
    .op_b_i       (dot_op_b_i),
    .op_c_i       (dot_op_c_i),
    .spr_w_i      (spr_w),
    .spr_a_i      (spr_a),
    .result_o     (dot_result)
  );

  nn_spr_file u_spr (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex_valid_i    (ex_valid_o),
    .wb_ready_i    (wb_ready_i),
    .lsu_spr_i     (lsu_spr_i),
    .lsu_spr_sel_i (lsu_spr_sel_i),
    .data_rvalid_i (data_rvalid_i),
    .lsu_rdata_i   (lsu_rdata_i),
    .w_idx_i       (spr_w_idx_i),
    .a_idx_i       (spr_a_idx_i),
    .spr_w_o       (spr_w),
    .spr_a_o       (spr_a)
  );

  nn_writeback u_wb (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .dot_en_i               (dot_en_i),
    .lsu_en_i               (lsu_en_i),
    .dot_spr_i              (dot_spr_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .alu_result_i           (alu_result),
    .dot_result_i           (dot_result),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_alu_waddr2_i   (regfile_alu_waddr2_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_err_i              (lsu_err_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

//--- dv/nn_ex_assertions.sv
// Concurrent checks on the execute stage WB flags and handshake, bound into the top level

`timescale 1ns/10ps

module nn_ex_assertions (
  input logic clk,
  input logic rst_n,
  input logic ex_valid_o,
  input logic wb_ready_i,
  input logic dot_spr_i,
  input logic regfile_we_i,
  input logic regfile_we_wb_o
);

  // Write port quiet straight out of reset
  a_wb_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !regfile_we_wb_o)
    else $error("WB write enable high in the first cycle after reset");

  // GPR load and load-and-compute dot never share an instruction
  a_no_load_with_spr_dot: assert property (@(posedge clk) disable iff (!rst_n)
    !(ex_valid_o && dot_spr_i && regfile_we_i))
    else $error("Accepted instruction carries both a GPR load and a special-register dot");

  a_bubble_clears_wb: assert property (@(posedge clk) disable iff (!rst_n)
    (!ex_valid_o && wb_ready_i) |=> !regfile_we_wb_o)
    else $error("WB write enable high after a bubble"); // Flags clear on a bubble

endmodule

bind nn_ex_stage nn_ex_assertions i_asrt (
  .clk             (clk),
  .rst_n           (rst_n),
  .ex_valid_o      (ex_valid_o),
  .wb_ready_i      (wb_ready_i),
  .dot_spr_i       (dot_spr_i),
  .regfile_we_i    (regfile_we_i),
  .regfile_we_wb_o (regfile_we_wb_o)
);

//--- dv/tb_nn_ex_stage.sv
// Self-checking testbench for the execute stage; random instructions checked against a model

`timescale 1ns/10ps

`include "nn_ex_defines.svh"

module tb_nn_ex_stage;

  localparam int N_INSTR    = 2000;
  localparam int MAX_CYCLES = 3 * N_INSTR + 50;

  logic clk;
  logic rst_n;
  logic alu_en_i;
  nn_ex_pkg::nn_alu_op_e alu_op_i;
  logic [`NN_XLEN-1:0] alu_operand_a_i;
  logic [`NN_XLEN-1:0] alu_operand_b_i;
  logic branch_in_ex_i;
  logic dot_en_i;
  nn_ex_pkg::nn_dot_mode_e dot_mode_i;
  logic dot_signed_i;
  logic [`NN_XLEN-1:0] dot_op_a_i;
  logic [`NN_XLEN-1:0] dot_op_b_i;
  logic [`NN_XLEN-1:0] dot_op_c_i;
  logic dot_spr_i;
  logic [`NN_WSPR_IW-1:0] spr_w_idx_i;
  logic [`NN_ASPR_IW-1:0] spr_a_idx_i;
  logic regfile_alu_we_i;
  logic [`NN_REG_AW-1:0] regfile_alu_waddr_i;
  logic [`NN_REG_AW-1:0] regfile_alu_waddr2_i;
  logic lsu_en_i;
  logic regfile_we_i;
  logic [`NN_REG_AW-1:0] regfile_waddr_i;
  logic lsu_spr_i;
  logic [2:0] lsu_spr_sel_i;
  logic lsu_err_i;
  logic lsu_ready_ex_i;
  logic [`NN_XLEN-1:0] lsu_rdata_i;
  logic data_rvalid_i;
  logic wb_ready_i;
  logic branch_decision_o;
  logic regfile_alu_we_fw_o;
  logic [`NN_REG_AW-1:0] regfile_alu_waddr_fw_o;
  logic [`NN_XLEN-1:0] regfile_alu_wdata_fw_o;
  logic regfile_we_wb_o;
  logic [`NN_REG_AW-1:0] regfile_waddr_wb_o;
  logic [`NN_XLEN-1:0] regfile_wdata_wb_o;
  logic ex_ready_o;
  logic ex_valid_o;

  // Reference model state
  logic [31:0] m_wspr [`NN_N_WSPR];
  logic [31:0] m_aspr [`NN_N_ASPR];
  logic        m_load_we;
  logic        m_dot_wb;   // Pending load-and-compute result
  logic        m_spr_pend;
  logic [2:0]  m_spr_sel;
  logic [`NN_REG_AW-1:0] m_load_waddr;
  logic [`NN_REG_AW-1:0] m_waddr2;
  logic [31:0] m_dot_result;

  int unsigned cycles;

  nn_ex_stage i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("test failed");
    $fatal(1, "cycle limit reached");
  end

  //////////////////////////////////////////////////
  // Model functions
  //////////////////////////////////////////////////

  function automatic logic [31:0] alu_model(input nn_ex_pkg::nn_alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
    case (op)
      nn_ex_pkg::ALU_ADD: return a + b;
      nn_ex_pkg::ALU_SUB: return a - b;
      nn_ex_pkg::ALU_SLT: return {31'd0, $signed(a) < $signed(b)};
      default:            return {31'd0, a == b};
    endcase
  endfunction

  function automatic logic [31:0] dot_model(input logic mode16, input logic sgn,
                                            input logic [31:0] a, input logic [31:0] b,
                                            input logic [31:0] c);
    logic signed [63:0] acc;
    logic signed [63:0] la;
    logic signed [63:0] lb;
    acc = '0;
    if (mode16) begin
      for (int i = 0; i < 2; i++) begin
        la  = {{48{sgn & a[16*i+15]}}, a[16*i +: 16]};
        lb  = {{48{sgn & b[16*i+15]}}, b[16*i +: 16]};
        acc = acc + la * lb;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        la  = {{56{sgn & a[8*i+7]}}, a[8*i +: 8]};
        lb  = {{56{sgn & b[8*i+7]}}, b[8*i +: 8]};
        acc = acc + la * lb;
      end
    end
    return c + acc[31:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic clear_instr();
    alu_en_i         = 1'b0;
    branch_in_ex_i   = 1'b0;
    dot_en_i         = 1'b0;
    dot_spr_i        = 1'b0;
    regfile_alu_we_i = 1'b0;
    lsu_en_i         = 1'b0;
    regfile_we_i     = 1'b0;
    lsu_spr_i        = 1'b0;
  endtask

  task automatic drive_instr();
    logic [31:0] rnd;
    logic [31:0] addr;
    rnd  = $urandom;
    addr = $urandom;
    clear_instr();
    alu_operand_a_i = $urandom;
    alu_operand_b_i = (rnd[5:4] == 2'd0) ? alu_operand_a_i : $urandom; // Hit EQ now and then
    dot_op_a_i      = $urandom;
    dot_op_b_i      = $urandom;
    dot_op_c_i      = $urandom;
    alu_op_i        = nn_ex_pkg::nn_alu_op_e'(rnd[9:8]);
    dot_mode_i      = nn_ex_pkg::nn_dot_mode_e'(rnd[10]);
    dot_signed_i    = rnd[11];
    spr_w_idx_i     = rnd[13:12];
    spr_a_idx_i     = rnd[14];
    lsu_spr_sel_i   = rnd[17:15];
    lsu_err_i       = (rnd[20:18] == 3'd0);
    regfile_alu_waddr_i  = addr[5:0];
    regfile_alu_waddr2_i = addr[13:8];
    regfile_waddr_i      = addr[21:16];
    case (rnd[2:0])
      3'd0, 3'd1: begin // Plain ALU
        alu_en_i         = 1'b1;
        regfile_alu_we_i = 1'b1;
      end
      3'd2: begin
        alu_en_i       = 1'b1;
        branch_in_ex_i = 1'b1;
        alu_op_i       = nn_ex_pkg::nn_alu_op_e'({1'b1, rnd[8]});
      end
      3'd3, 3'd4: begin // Dot on port operands
        dot_en_i         = 1'b1;
        regfile_alu_we_i = 1'b1;
      end
      3'd5: begin
        lsu_en_i  = 1'b1;
        lsu_spr_i = 1'b1;
      end
      3'd6: begin // Load-and-compute
        alu_en_i         = 1'b1;
        dot_en_i         = 1'b1;
        dot_spr_i        = 1'b1;
        regfile_alu_we_i = 1'b1;
      end
      default: begin
        lsu_en_i     = 1'b1;
        regfile_we_i = 1'b1;
      end
    endcase
  endtask

  // One clock of EX; returns whether the instruction leaves EX
  task automatic run_cycle(output logic leaves);
    logic [31:0] r;
    logic        exp_ready;
    logic        exp_valid;
    logic [31:0] exp_alu;
    logic [31:0] exp_dot;
    logic [31:0] exp_fw;
    r              = $urandom;
    wb_ready_i     = (r[7:0] >= 8'd51);   // About 20% stall
    lsu_ready_ex_i = (r[15:8] >= 8'd51);
    data_rvalid_i  = (r[17:16] != 2'd0);
    lsu_rdata_i    = $urandom;
    #1;
    exp_ready = (lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
    exp_valid = (alu_en_i | dot_en_i | lsu_en_i) & lsu_ready_ex_i & wb_ready_i;
    exp_alu   = alu_model(alu_op_i, alu_operand_a_i, alu_operand_b_i);
    exp_dot   = dot_model(dot_mode_i == nn_ex_pkg::DOT16, dot_signed_i,
                          dot_spr_i ? m_wspr[spr_w_idx_i] : dot_op_a_i,
                          dot_spr_i ? m_aspr[spr_a_idx_i] : dot_op_b_i, dot_op_c_i);
    exp_fw    = (dot_en_i && !dot_spr_i) ? exp_dot : exp_alu;
    check_value("ex_ready_o", 32'(ex_ready_o), 32'(exp_ready));
    check_value("ex_valid_o", 32'(ex_valid_o), 32'(exp_valid));
    check_value("branch_decision_o", 32'(branch_decision_o),
                (alu_op_i == nn_ex_pkg::ALU_SLT || alu_op_i == nn_ex_pkg::ALU_EQ) ? exp_alu : 0);
    check_value("regfile_alu_we_fw_o", 32'(regfile_alu_we_fw_o), 32'(regfile_alu_we_i));
    check_value("regfile_alu_waddr_fw_o", 32'(regfile_alu_waddr_fw_o),
                32'(regfile_alu_waddr_i));
    check_value("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp_fw);
    check_value("regfile_we_wb_o", 32'(regfile_we_wb_o), 32'(m_load_we | m_dot_wb));
    if (m_dot_wb) begin
      check_value("regfile_waddr_wb_o", 32'(regfile_waddr_wb_o), 32'(m_waddr2));
      check_value("regfile_wdata_wb_o", regfile_wdata_wb_o, m_dot_result);
    end else if (m_load_we) begin
      check_value("regfile_waddr_wb_o", 32'(regfile_waddr_wb_o), 32'(m_load_waddr));
      check_value("regfile_wdata_wb_o", regfile_wdata_wb_o, lsu_rdata_i);
    end
    // State as it will be after the coming edge
    if (m_spr_pend && data_rvalid_i) begin
      if (m_spr_sel[2]) m_wspr[m_spr_sel[1:0]] = lsu_rdata_i;
      else              m_aspr[m_spr_sel[0]]   = lsu_rdata_i;
    end
    if (exp_valid) begin
      m_load_we    = regfile_we_i & ~lsu_err_i;
      m_dot_wb     = dot_spr_i & dot_en_i;
      m_spr_pend   = lsu_spr_i;
      m_spr_sel    = lsu_spr_sel_i;
      m_load_waddr = regfile_waddr_i;
      m_waddr2     = regfile_alu_waddr2_i;
      m_dot_result = exp_dot;
    end else if (wb_ready_i) begin
      m_load_we  = 1'b0;
      m_dot_wb   = 1'b0;
      m_spr_pend = 1'b0;
    end
    leaves = exp_ready;
    @(negedge clk);
  endtask

  initial begin
    logic leaves;
    void'($urandom(40718));
    clear_instr();
    alu_op_i = nn_ex_pkg::ALU_ADD;
    dot_mode_i = nn_ex_pkg::DOT8;
    {alu_operand_a_i, alu_operand_b_i, dot_op_a_i, dot_op_b_i, dot_op_c_i} = '0;
    {dot_signed_i, spr_w_idx_i, spr_a_idx_i, lsu_spr_sel_i, lsu_err_i} = '0;
    {regfile_alu_waddr_i, regfile_alu_waddr2_i, regfile_waddr_i} = '0;
    {lsu_rdata_i, data_rvalid_i, lsu_ready_ex_i, wb_ready_i} = '0;
    for (int i = 0; i < `NN_N_WSPR; i++) m_wspr[i] = '0;
    for (int i = 0; i < `NN_N_ASPR; i++) m_aspr[i] = '0;
    {m_load_we, m_dot_wb, m_spr_pend, m_spr_sel} = '0;
    {m_load_waddr, m_waddr2, m_dot_result} = '0;
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int n = 0; n < N_INSTR; n++) begin
      drive_instr();
      leaves = 1'b0;
      while (!leaves) run_cycle(leaves); // Held until EX lets it go
    end
    $display("test passed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+logic
logic/nn_ex_pkg.sv
logic/nn_alu.sv
logic/nn_dotp_unit.sv
logic/nn_spr_file.sv
logic/nn_writeback.sv
logic/nn_ex_stage.sv
dv/nn_ex_assertions.sv
dv/tb_nn_ex_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_nn_ex_stage
FILELIST  := vlog.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard logic/*.sv logic/*.svh dv/*.sv)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
